/* Makefile */
# Verilator build and run of the subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_subsystem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
verilog/soc_pkg.sv
verilog/axil_slave_port.sv
verilog/soc_addr_decoder.sv
verilog/boot_rom.sv
verilog/clint_timer.sv
verilog/debug_req_gate.sv
verilog/soc_subsystem.sv
testbench/tb_soc_subsystem.sv

/* testbench/soc_tests.txt */
# op addr wdata strb exp_data exp_resp name (all numbers in hex)
# op W write, R read, P rtc pulses (addr = count), G debug gate (addr = cycle), I irq {ipi, timer}
G 0000003E 00000000 0 00000000 0 debug_masked_in_window
G 00000042 00000000 0 00000001 0 debug_open_after_window
I 00000000 00000000 0 00000000 0 irq_idle_after_reset
R 00010000 00000000 0 B0070000 0 rom_word_0
R 00010014 00000000 0 B0070005 0 rom_word_5
R 0001003C 00000000 0 B007000F 0 rom_word_15
R 00010080 00000000 0 00000000 0 rom_past_table
R 00000000 00000000 0 00000000 3 read_unmapped_low
W 00000000 12345678 F 00000000 3 write_unmapped_low
R 30000000 00000000 0 00000000 3 read_unmapped_high
W 30000000 12345678 F 00000000 3 write_unmapped_high
W 00010000 DEADBEEF F 00000000 2 write_rom_rejected
R 00010000 00000000 0 B0070000 0 rom_word_0_unchanged
W 02000000 00000001 F 00000000 0 msip_set
I 00000000 00000000 0 00000002 0 ipi_raised
R 02000000 00000000 0 00000001 0 msip_readback
W 02000000 00000000 F 00000000 0 msip_clear
I 00000000 00000000 0 00000000 0 ipi_lowered
W 0200BFF8 00000100 F 00000000 0 mtime_lo_write
R 0200BFF8 00000000 0 00000100 0 mtime_lo_readback
W 0200BFF8 00000000 F 00000000 0 mtime_lo_clear
W 0200BFFC 00000000 F 00000000 0 mtime_hi_clear
P 00000005 00000000 0 00000000 0 rtc_five_pulses
R 0200BFF8 00000000 0 00000005 0 mtime_counts_pulses
W 02004004 00000000 F 00000000 0 mtimecmp_hi_clear
W 02004000 DEADBE07 1 00000000 0 mtimecmp_lo_byte0
R 02004000 00000000 0 FFFFFF07 0 mtimecmp_lo_byte0_readback
W 02004000 000000FF E 00000000 0 mtimecmp_lo_upper_bytes
R 02004000 00000000 0 00000007 0 mtimecmp_lo_readback
I 00000000 00000000 0 00000000 0 timer_irq_still_low
P 00000002 00000000 0 00000000 0 rtc_two_pulses
I 00000000 00000000 0 00000001 0 timer_irq_raised

/* testbench/tb_soc_subsystem.sv */
// Testbench for the subsystem top with AXI4-Lite tasks and file-driven test vectors
`timescale 1ns/1ps
`default_nettype none

module tb_soc_subsystem;

  localparam int    CLK_PERIOD    = 40;
  localparam int    SAMPLE_DELAY  = 10;
  localparam int    RESET_CYCLES  = 10;
  localparam int    WAIT_LIMIT    = 200;
  localparam int    RTC_HALF      = 3;
  localparam int    SETTLE_CYCLES = 4;
  localparam int    NAME_W        = 8 * 40;
  localparam int    LINE_W        = 8 * 160;
  localparam string TEST_FILE     = "testbench/soc_tests.txt";

  logic           clk;
  logic           rst_n;
  logic           rtc;
  logic           debug_req;
  logic           debug_req_out;
  logic           awvalid;
  logic           awready;
  soc_pkg::addr_t awaddr;
  logic           wvalid;
  logic           wready;
  soc_pkg::data_t wdata;
  soc_pkg::strb_t wstrb;
  logic           bvalid;
  logic           bready;
  soc_pkg::resp_t bresp;
  logic           arvalid;
  logic           arready;
  soc_pkg::addr_t araddr;
  logic           rvalid;
  logic           rready;
  soc_pkg::data_t rdata;
  soc_pkg::resp_t rresp;
  logic           timer_irq;
  logic           ipi;
  int             cycles_since_reset;
  integer         seed;
  int             tests_run;
  int             tests_failed;

  soc_subsystem i_soc_subsystem (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .debug_req_i ( debug_req     ),
    .debug_req_o ( debug_req_out ),
    .awvalid_i   ( awvalid       ),
    .awready_o   ( awready       ),
    .awaddr_i    ( awaddr        ),
    .wvalid_i    ( wvalid        ),
    .wready_o    ( wready        ),
    .wdata_i     ( wdata         ),
    .wstrb_i     ( wstrb         ),
    .bvalid_o    ( bvalid        ),
    .bready_i    ( bready        ),
    .bresp_o     ( bresp         ),
    .arvalid_i   ( arvalid       ),
    .arready_o   ( arready       ),
    .araddr_i    ( araddr        ),
    .rvalid_o    ( rvalid        ),
    .rready_i    ( rready        ),
    .rdata_o     ( rdata         ),
    .rresp_o     ( rresp         ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           )
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Rising edges seen since reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycles_since_reset <= 0;
    end else begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  // --------------------
  // Reporting
  // --------------------
  task automatic report_ok(input logic [NAME_W-1:0] name);
    tests_run++;
    $display("ok     %0s", name);
  endtask

  task automatic report_mismatch(input logic [NAME_W-1:0] name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    tests_run++;
    tests_failed++;
    $display("Error %0s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic report_problem(input logic [NAME_W-1:0] name, input string what);
    tests_run++;
    tests_failed++;
    $display("Failure in %0s: %0s", name, what);
  endtask

  // --------------------
  // Bus and pin drivers
  // --------------------
  task automatic wait_gap();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
  endtask

  task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                           input soc_pkg::strb_t strb, output soc_pkg::resp_t resp,
                           output logic timed_out);
    int waited;
    resp      = '0;
    timed_out = 1'b0;
    waited    = 0;
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    #(SAMPLE_DELAY);
    while (!(awready && wready) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      waited++;
    end
    timed_out = !(awready && wready);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!timed_out && !bvalid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (bvalid) begin
      resp = bresp;
    end else begin
      timed_out = 1'b1;
    end
  endtask

  task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                          output soc_pkg::resp_t resp, output logic timed_out);
    int waited;
    data      = '0;
    resp      = '0;
    timed_out = 1'b0;
    waited    = 0;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    #(SAMPLE_DELAY);
    while (!arready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      waited++;
    end
    timed_out = !arready;
    @(negedge clk);
    arvalid = 1'b0;
    waited  = 0;
    while (!timed_out && !rvalid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rvalid) begin
      data = rdata;
      resp = rresp;
    end else begin
      timed_out = 1'b1;
    end
  endtask

  // Each pulse spans several clocks so the synchronizer sees it
  task automatic rtc_pulses(input int count);
    @(negedge clk);
    repeat (count) begin
      rtc = 1'b1;
      repeat (RTC_HALF) @(negedge clk);
      rtc = 1'b0;
      repeat (RTC_HALF) @(negedge clk);
    end
    repeat (SETTLE_CYCLES) @(negedge clk);
  endtask

  // --------------------
  // One line of the test file
  // --------------------
  task automatic run_test(input logic [7:0] op, input soc_pkg::addr_t addr,
                          input soc_pkg::data_t wr_data, input soc_pkg::strb_t strb,
                          input soc_pkg::data_t exp_data, input soc_pkg::resp_t exp_resp,
                          input logic [NAME_W-1:0] name);
    soc_pkg::data_t data;
    soc_pkg::resp_t resp;
    logic           timed_out;
    int             waited;
    case (op)
      "W": begin
        wait_gap();
        bus_write(addr, wr_data, strb, resp, timed_out);
        if (timed_out) begin
          report_problem(name, "the DUT never completed the write handshake");
        end else if (resp !== exp_resp) begin
          report_mismatch(name, 32'(exp_resp), 32'(resp));
        end else begin
          report_ok(name);
        end
      end
      "R": begin
        wait_gap();
        bus_read(addr, data, resp, timed_out);
        if (timed_out) begin
          report_problem(name, "the DUT never completed the read handshake");
        end else if (resp !== exp_resp) begin
          report_mismatch(name, 32'(exp_resp), 32'(resp));
        end else if (data !== exp_data) begin
          report_mismatch(name, exp_data, data);
        end else begin
          report_ok(name);
        end
      end
      "P": begin
        // Stimulus only, the following lines check its effect
        rtc_pulses(int'(addr));
      end
      "I": begin
        @(negedge clk);
        data = {30'b0, ipi, timer_irq};
        if (data !== exp_data) begin
          report_mismatch(name, exp_data, data);
        end else begin
          report_ok(name);
        end
      end
      "G": begin
        waited = 0;
        @(negedge clk);
        while (cycles_since_reset < int'(addr) && waited < WAIT_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        data = {31'b0, debug_req_out};
        if (cycles_since_reset != int'(addr)) begin
          report_problem(name, "the requested cycle after reset was missed");
        end else if (data !== exp_data) begin
          report_mismatch(name, exp_data, data);
        end else begin
          report_ok(name);
        end
      end
      default: begin
        report_problem(name, "unknown operation in the test file");
      end
    endcase
  endtask

  task automatic check_reset_state();
    soc_pkg::data_t data;
    @(negedge clk);
    data = {28'b0, bvalid, rvalid, timer_irq, ipi};
    if (data !== '0) begin
      report_mismatch("reset_state", 32'h0, data);
    end else begin
      report_ok("reset_state");
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int                  fd;
    int                  code;
    logic [LINE_W-1:0]   line_buf;
    logic [7:0]          op;
    soc_pkg::addr_t      addr;
    soc_pkg::data_t      wr_data;
    soc_pkg::strb_t      strb;
    soc_pkg::data_t      exp_data;
    soc_pkg::resp_t      exp_resp;
    logic [NAME_W-1:0]   name;
    seed         = 31;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    rtc          = 1'b0;
    // Debug request held from reset on to probe the delay window
    debug_req    = 1'b1;
    awvalid      = 1'b0;
    awaddr       = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    bready       = 1'b1;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      tests_failed++;
      $display("Could not open the test vector file %0s", TEST_FILE);
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        name     = '0;
        op       = 8'h0;
        code     = $fgets(line_buf, fd);
        if (code > 0) begin
          code = $sscanf(line_buf, "%s %h %h %h %h %h %s", op, addr, wr_data, strb,
                         exp_data, exp_resp, name);
          if (code == 7 && op != "#") begin
            run_test(op, addr, wr_data, strb, exp_data, exp_resp, name);
          end else if (code >= 1 && op != "#") begin
            tests_failed++;
            $display("A line of the test file could not be parsed");
          end
        end
      end
      $fclose(fd);
    end
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/axil_slave_port.sv */
// AXI4-Lite slave port that issues one single-cycle memory request per transfer
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Write address
  input  logic               awvalid_i,
  output logic               awready_o,
  input  soc_pkg::addr_t     awaddr_i,
  // Write data
  input  logic               wvalid_i,
  output logic               wready_o,
  input  soc_pkg::data_t     wdata_i,
  input  soc_pkg::strb_t     wstrb_i,
  // Write response
  output logic               bvalid_o,
  input  logic               bready_i,
  output soc_pkg::resp_t     bresp_o,
  // Read address
  input  logic               arvalid_i,
  output logic               arready_o,
  input  soc_pkg::addr_t     araddr_i,
  // Read data
  output logic               rvalid_o,
  input  logic               rready_i,
  output soc_pkg::data_t     rdata_o,
  output soc_pkg::resp_t     rresp_o,
  // Memory request toward the decoder
  output logic               mem_req_o,
  output logic               mem_we_o,
  output soc_pkg::addr_t     mem_addr_o,
  output soc_pkg::data_t     mem_wdata_o,
  output soc_pkg::strb_t     mem_wstrb_o,
  input  soc_pkg::data_t     mem_rdata_i,
  input  soc_pkg::resp_t     mem_resp_i
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } state_e;

  state_e         state_q;
  state_e         state_d;
  logic           wr_go;
  logic           rd_go;
  soc_pkg::resp_t bresp_q;
  soc_pkg::data_t rdata_q;
  soc_pkg::resp_t rresp_q;

  // Write wins when both channels are ready in idle
  assign wr_go = (state_q == IDLE) && awvalid_i && wvalid_i;
  assign rd_go = (state_q == IDLE) && !wr_go && arvalid_i;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  // --------------------
  // Memory request
  // --------------------
  assign mem_req_o   = wr_go | rd_go;
  assign mem_we_o    = wr_go;
  assign mem_addr_o  = wr_go ? awaddr_i : araddr_i;
  assign mem_wdata_o = wdata_i;
  assign mem_wstrb_o = wr_go ? wstrb_i : '0;

  // Responses held until the master takes them
  assign bvalid_o = (state_q == WRITE_RESP);
  assign bresp_o  = bresp_q;
  assign rvalid_o = (state_q == READ_RESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wr_go) begin
          state_d = WRITE_RESP;
        end else if (rd_go) begin
          state_d = READ_RESP;
        end
      end
      WRITE_RESP: begin
        if (bready_i) state_d = IDLE;
      end
      READ_RESP: begin
        if (rready_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the decoder answer in the request cycle
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bresp_q <= mem_resp_i;
    end
    if (rd_go) begin
      rdata_q <= mem_rdata_i;
      rresp_q <= mem_resp_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/boot_rom.sv */
// Sixteen-word combinational boot ROM
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic           rom_req_i,
  input  soc_pkg::addr_t rom_addr_i,
  output soc_pkg::data_t rom_rdata_o
);

  soc_pkg::addr_t rom_ofs;
  logic           in_table;
  soc_pkg::data_t word;

  assign rom_ofs  = rom_addr_i - soc_pkg::ROM_BASE;
  assign in_table = rom_ofs < soc_pkg::addr_t'(soc_pkg::ROM_WORDS * 4);

  always_comb begin
    case (rom_ofs[5:2])
      4'd0:    word = 32'hB007_0000;
      4'd1:    word = 32'hB007_0001;
      4'd2:    word = 32'hB007_0002;
      4'd3:    word = 32'hB007_0003;
      4'd4:    word = 32'hB007_0004;
      4'd5:    word = 32'hB007_0005;
      4'd6:    word = 32'hB007_0006;
      4'd7:    word = 32'hB007_0007;
      4'd8:    word = 32'hB007_0008;
      4'd9:    word = 32'hB007_0009;
      4'd10:   word = 32'hB007_000A;
      4'd11:   word = 32'hB007_000B;
      4'd12:   word = 32'hB007_000C;
      4'd13:   word = 32'hB007_000D;
      4'd14:   word = 32'hB007_000E;
      default: word = 32'hB007_000F;
    endcase
  end

  // Past the table the region reads as zero
  assign rom_rdata_o = (rom_req_i && in_table) ? word : '0;

endmodule

`default_nettype wire

/* verilog/clint_timer.sv */
// Machine timer, timer compare, software interrupt and rtc edge detection
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output soc_pkg::data_t rdata_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);

  localparam int DW = soc_pkg::DATA_W;

  soc_pkg::addr_t  word_ofs;
  logic            wr_en;
  logic            sel_msip;
  logic            sel_cmp_lo;
  logic            sel_cmp_hi;
  logic            sel_time_lo;
  logic            sel_time_hi;
  logic            msip_q;
  soc_pkg::mtime_t mtime_q;
  soc_pkg::mtime_t mtime_d;
  soc_pkg::mtime_t mtimecmp_q;
  soc_pkg::mtime_t mtimecmp_d;
  logic [1:0]      rtc_sync_q;
  logic            rtc_prev_q;
  logic            rtc_tick;
  logic            irq_q;

  // Merge write data into a word under the byte strobes
  function automatic soc_pkg::data_t apply_strb(soc_pkg::data_t old_w,
                                                soc_pkg::data_t new_w,
                                                soc_pkg::strb_t strb);
    soc_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < DW / 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
    end
    return res;
  endfunction

  // --------------------
  // Register select
  // --------------------
  assign word_ofs    = (addr_i - soc_pkg::CLINT_BASE) & ~soc_pkg::addr_t'(3);
  assign sel_msip    = word_ofs == soc_pkg::MSIP_OFS;
  assign sel_cmp_lo  = word_ofs == soc_pkg::MTIMECMP_OFS;
  assign sel_cmp_hi  = word_ofs == soc_pkg::MTIMECMP_OFS + soc_pkg::addr_t'(4);
  assign sel_time_lo = word_ofs == soc_pkg::MTIME_OFS;
  assign sel_time_hi = word_ofs == soc_pkg::MTIME_OFS + soc_pkg::addr_t'(4);
  assign wr_en       = req_i && we_i;

  always_comb begin
    rdata_o = '0;
    if (sel_msip) rdata_o = {{(DW-1){1'b0}}, msip_q};
    if (sel_cmp_lo) rdata_o = mtimecmp_q[DW-1:0];
    if (sel_cmp_hi) rdata_o = mtimecmp_q[63:DW];
    if (sel_time_lo) rdata_o = mtime_q[DW-1:0];
    if (sel_time_hi) rdata_o = mtime_q[63:DW];
  end

  // rtc crosses in through two flops and a rising-edge detect
  assign rtc_tick = rtc_sync_q[1] && !rtc_prev_q;

  always_comb begin
    mtime_d = mtime_q;
    if (wr_en && sel_time_lo) begin
      mtime_d[DW-1:0] = apply_strb(mtime_q[DW-1:0], wdata_i, wstrb_i);
    end else if (wr_en && sel_time_hi) begin
      mtime_d[63:DW] = apply_strb(mtime_q[63:DW], wdata_i, wstrb_i);
    end else if (rtc_tick) begin
      mtime_d = mtime_q + 64'd1;
    end
  end

  always_comb begin
    mtimecmp_d = mtimecmp_q;
    if (wr_en && sel_cmp_lo) begin
      mtimecmp_d[DW-1:0] = apply_strb(mtimecmp_q[DW-1:0], wdata_i, wstrb_i);
    end
    if (wr_en && sel_cmp_hi) begin
      mtimecmp_d[63:DW] = apply_strb(mtimecmp_q[63:DW], wdata_i, wstrb_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      if (wr_en && sel_msip && wstrb_i[0]) msip_q <= wdata_i[0];
      // Registered compare trails a register change by one cycle
      irq_q <= mtime_q >= mtimecmp_q;
    end
  end

  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

/* verilog/debug_req_gate.sv */
// Post-reset delay window that masks the external debug request
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [soc_pkg::DEBUG_CNT_W-1:0] cnt_q;
  logic                            window_open;

  // Boot code gets this many cycles before a debug halt can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DEBUG_CNT_W'(soc_pkg::DEBUG_DELAY_CYCLES);
    end else if (!window_open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign window_open = (cnt_q == '0);
  assign debug_req_o = window_open && debug_req_i;

endmodule

`default_nettype wire

/* verilog/soc_addr_decoder.sv */
// Address decoder with request steering, read data mux and error responses
`timescale 1ns/1ps
`default_nettype none

module soc_addr_decoder (
  input  logic           mem_req_i,
  input  logic           mem_we_i,
  input  soc_pkg::addr_t mem_addr_i,
  output soc_pkg::data_t mem_rdata_o,
  output soc_pkg::resp_t mem_resp_o,
  // Boot ROM
  output logic           rom_req_o,
  input  soc_pkg::data_t rom_rdata_i,
  // Timer block
  output logic           clint_req_o,
  output logic           clint_we_o,
  input  soc_pkg::data_t clint_rdata_i
);

  logic rom_hit;
  logic clint_hit;

  // Subtract first so addresses below the base wrap and miss
  assign rom_hit   = (mem_addr_i - soc_pkg::ROM_BASE) < soc_pkg::ROM_LEN;
  assign clint_hit = (mem_addr_i - soc_pkg::CLINT_BASE) < soc_pkg::CLINT_LEN;

  // ROM writes never reach the ROM
  assign rom_req_o   = mem_req_i && rom_hit && !mem_we_i;
  assign clint_req_o = mem_req_i && clint_hit;
  assign clint_we_o  = mem_req_i && clint_hit && mem_we_i;

  always_comb begin
    mem_rdata_o = '0;
    mem_resp_o  = soc_pkg::RESP_OKAY;
    if (rom_hit) begin
      if (mem_we_i) begin
        mem_resp_o = soc_pkg::RESP_SLVERR;
      end else begin
        mem_rdata_o = rom_rdata_i;
      end
    end else if (clint_hit) begin
      if (!mem_we_i) begin
        mem_rdata_o = clint_rdata_i;
      end
    end else begin
      mem_resp_o = soc_pkg::RESP_DECERR;
    end
  end

endmodule

`default_nettype wire

/* verilog/soc_pkg.sv */
// Bus widths and types, response codes, address map, timer and debug constants
`default_nettype none

package soc_pkg;

  // --------------------
  // Bus widths and types
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;
  typedef logic [1:0]          resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // --------------------
  // Address map
  // --------------------
  localparam addr_t ROM_BASE  = 32'h0001_0000;
  localparam addr_t ROM_LEN   = 32'h0001_0000;
  localparam int    ROM_WORDS = 16;

  localparam addr_t CLINT_BASE   = 32'h0200_0000;
  localparam addr_t CLINT_LEN    = 32'h0000_C000;
  // Timer block offsets with each high word 4 bytes above its low word
  localparam addr_t MSIP_OFS     = 32'h0000_0000;
  localparam addr_t MTIMECMP_OFS = 32'h0000_4000;
  localparam addr_t MTIME_OFS    = 32'h0000_BFF8;

  // --------------------
  // Timer and debug
  // --------------------
  typedef logic [63:0] mtime_t;

  // Shortened from 500 so the window closes quickly in simulation
  localparam int DEBUG_DELAY_CYCLES = 64;
  localparam int DEBUG_CNT_W        = $clog2(DEBUG_DELAY_CYCLES + 1);

endpackage

`default_nettype wire

/* verilog/soc_subsystem.sv */
// Subsystem top with bus port, address decoder, boot ROM, timer and debug gate
`timescale 1ns/1ps
`default_nettype none

module soc_subsystem (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           debug_req_i,
  output logic           debug_req_o,
  input  logic           awvalid_i,
  output logic           awready_o,
  input  soc_pkg::addr_t awaddr_i,
  input  logic           wvalid_i,
  output logic           wready_o,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output logic           bvalid_o,
  input  logic           bready_i,
  output soc_pkg::resp_t bresp_o,
  input  logic           arvalid_i,
  output logic           arready_o,
  input  soc_pkg::addr_t araddr_i,
  output logic           rvalid_o,
  input  logic           rready_i,
  output soc_pkg::data_t rdata_o,
  output soc_pkg::resp_t rresp_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);

  logic           mem_req;
  logic           mem_we;
  soc_pkg::addr_t mem_addr;
  soc_pkg::data_t mem_wdata;
  soc_pkg::strb_t mem_wstrb;
  soc_pkg::data_t mem_rdata;
  soc_pkg::resp_t mem_resp;
  logic           rom_req;
  soc_pkg::data_t rom_rdata;
  logic           clint_req;
  logic           clint_we;
  soc_pkg::data_t clint_rdata;

  // --------------------
  // Bus side
  // --------------------
  axil_slave_port i_axil_slave_port (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .awvalid_i   ( awvalid_i ),
    .awready_o   ( awready_o ),
    .awaddr_i    ( awaddr_i  ),
    .wvalid_i    ( wvalid_i  ),
    .wready_o    ( wready_o  ),
    .wdata_i     ( wdata_i   ),
    .wstrb_i     ( wstrb_i   ),
    .bvalid_o    ( bvalid_o  ),
    .bready_i    ( bready_i  ),
    .bresp_o     ( bresp_o   ),
    .arvalid_i   ( arvalid_i ),
    .arready_o   ( arready_o ),
    .araddr_i    ( araddr_i  ),
    .rvalid_o    ( rvalid_o  ),
    .rready_i    ( rready_i  ),
    .rdata_o     ( rdata_o   ),
    .rresp_o     ( rresp_o   ),
    .mem_req_o   ( mem_req   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_wstrb_o ( mem_wstrb ),
    .mem_rdata_i ( mem_rdata ),
    .mem_resp_i  ( mem_resp  )
  );

  soc_addr_decoder i_soc_addr_decoder (
    .mem_req_i     ( mem_req     ),
    .mem_we_i      ( mem_we      ),
    .mem_addr_i    ( mem_addr    ),
    .mem_rdata_o   ( mem_rdata   ),
    .mem_resp_o    ( mem_resp    ),
    .rom_req_o     ( rom_req     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_req_o   ( clint_req   ),
    .clint_we_o    ( clint_we    ),
    .clint_rdata_i ( clint_rdata )
  );

  // --------------------
  // Targets
  // --------------------
  boot_rom i_boot_rom (
    .rom_req_i   ( rom_req   ),
    .rom_addr_i  ( mem_addr  ),
    .rom_rdata_o ( rom_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( clint_we    ),
    .addr_i      ( mem_addr    ),
    .wdata_i     ( mem_wdata   ),
    .wstrb_i     ( mem_wstrb   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire
